/* build.f */
+incdir+logic
logic/sampler_pkg.sv
logic/digest_buffer.sv
logic/position_decode.sv
logic/bit_insert.sv
logic/sampler_control.sv
logic/error_sampler.sv
tests/error_sampler_props.sv
tests/error_sampler_tb.sv

/* Makefile */
TOP := error_sampler_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	set -o pipefail; ./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

SHELL := /bin/bash

/* tests/error_sampler_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sampler_defines.svh"

module error_sampler_tb import sampler_pkg::*;;

    localparam int MAX_DIGESTS    = 24;
    localparam int CYC_PER_DIGEST = `WORDS_PER_DIGEST * 2 + 12;
    localparam int RUNS           = 3;
    localparam int TIMEOUT_CYCLES = RUNS * MAX_DIGESTS * CYC_PER_DIGEST + 2000;

    logic                       CLK;
    logic                       RESETN;
    logic                       ENABLE;
    logic                       DONE;
    logic [`SEED_WIDTH-1:0]     KECCAK_SEED;
    logic [`STATE_WIDTH-1:0]    KECCAK_M;
    logic                       KECCAK_INIT;
    logic                       KECCAK_ENABLE;
    logic                       KECCAK_DONE;
    logic [`STATE_WIDTH-1:0]    KECCAK_OUT;
    logic                       rden_e0;
    logic                       wren_e0;
    logic                       rden_e1;
    logic                       wren_e1;
    logic [`ADDR_WIDTH-1:0]     addr;
    logic [`WORD_WIDTH-1:0]     wdata;
    logic [`WORD_WIDTH-1:0]     rdata_e0;
    logic [`WORD_WIDTH-1:0]     rdata_e1;

    // Bank RAMs and their reference copies
    logic [`WORD_WIDTH-1:0]     mem_e0 [512];
    logic [`WORD_WIDTH-1:0]     mem_e1 [512];
    logic [`WORD_WIDTH-1:0]     ref_e0 [512];
    logic [`WORD_WIDTH-1:0]     ref_e1 [512];
    logic                       ram_clear;
    // Digests handed out in request order
    logic [`STATE_WIDTH-1:0]    digest_bank [MAX_DIGESTS];
    int                         served;
    int                         countdown;
    int                         init_count;
    int                         enable_count;
    int                         write_count;
    int                         ref_digests;
    logic [31:0]                lcg_state;

    error_sampler DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // ----------------------------------------
    // Keccak, RAM and bus monitor models
    // ----------------------------------------
    always @(posedge CLK) begin
        KECCAK_DONE <= 1'b0;
        if (!RESETN) begin
            served    <= 0;
            countdown <= 0;
        end else if (KECCAK_ENABLE) begin
            countdown <= 5;
        end else if (countdown == 1) begin
            KECCAK_DONE <= 1'b1;
            KECCAK_OUT  <= digest_bank[(served < MAX_DIGESTS) ? served : MAX_DIGESTS - 1];
            served      <= served + 1;
            countdown   <= 0;
        end else if (countdown > 0) begin
            countdown <= countdown - 1;
        end
    end

    // One cycle read latency on both banks
    always @(posedge CLK) begin
        if (ram_clear) begin
            for (int i = 0; i < 512; i++) begin
                mem_e0[i] <= '0;
                mem_e1[i] <= '0;
            end
        end else begin
            if (wren_e0) mem_e0[addr] <= wdata;
            if (wren_e1) mem_e1[addr] <= wdata;
        end
        rdata_e0 <= rden_e0 ? mem_e0[addr] : 32'hdead_0000;
        rdata_e1 <= rden_e1 ? mem_e1[addr] : 32'hdead_0001;
    end

    always @(posedge CLK) begin
        if (!RESETN) begin
            init_count   <= 0;
            enable_count <= 0;
            write_count  <= 0;
        end else begin
            init_count   <= init_count + int'(KECCAK_INIT);
            enable_count <= enable_count + int'(KECCAK_ENABLE);
            write_count  <= write_count + int'(wren_e0 || wren_e1);
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $fatal(1);
    end

    // ----------------------------------------
    // Helpers and compare tasks
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word k is bytes 4k..4k+3 from the top, first byte least significant
    function automatic logic [31:0] get_word(logic [`STATE_WIDTH-1:0] d, int k);
        return {d[1575-32*k -: 8], d[1583-32*k -: 8], d[1591-32*k -: 8], d[1599-32*k -: 8]};
    endfunction

    function automatic logic [`STATE_WIDTH-1:0] put_word(logic [`STATE_WIDTH-1:0] d, int k,
                                                          logic [31:0] w);
        d[1599-32*k -: 8] = w[7:0];
        d[1591-32*k -: 8] = w[15:8];
        d[1583-32*k -: 8] = w[23:16];
        d[1575-32*k -: 8] = w[31:24];
        return d;
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(string name, logic [`WORD_WIDTH-1:0] got,
                              logic [`WORD_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_msg(string name, logic [`STATE_WIDTH-1:0] got,
                             logic [`STATE_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // Fresh random digest in every slot
    task automatic fill_digests();
        for (int d = 0; d < MAX_DIGESTS; d++) begin
            for (int j = 0; j < `STATE_WIDTH / 32; j++) begin
                lcg_state = lcg_next(lcg_state);
                digest_bank[d][32*j +: 32] = lcg_state;
            end
        end
    endtask

    task automatic new_seed();
        logic [`SEED_WIDTH-1:0] s;
        for (int j = 0; j < `SEED_WIDTH / 32; j++) begin
            lcg_state = lcg_next(lcg_state);
            s[32*j +: 32] = lcg_state;
        end
        @(posedge CLK);
        KECCAK_SEED <= s;
    endtask

    task automatic reset_dut();
        @(posedge CLK);
        RESETN    <= 1'b0;
        ram_clear <= 1'b1;
        ENABLE    <= 1'b0;
        repeat (5) @(posedge CLK);
        RESETN    <= 1'b1;
        ram_clear <= 1'b0;
        @(negedge CLK);
    endtask

    // Rejection, bank split and duplicate rules over the served digests
    task automatic build_reference();
        int          count;
        logic [31:0] w;
        logic [14:0] pos;
        logic [14:0] loc;
        for (int i = 0; i < 512; i++) begin
            ref_e0[i] = '0;
            ref_e1[i] = '0;
        end
        count       = 0;
        ref_digests = 0;
        for (int d = 0; d < MAX_DIGESTS && count < `ERROR_WEIGHT; d++) begin
            ref_digests = d + 1;
            for (int k = 0; k < `WORDS_PER_DIGEST && count < `ERROR_WEIGHT; k++) begin
                w   = get_word(digest_bank[d], k);
                pos = w[14:0];
                if (pos < 15'(`N_BITS)) begin
                    if (pos >= 15'(`R_BITS)) begin
                        loc = pos - 15'(`R_BITS);
                        if (!ref_e1[loc[13:5]][loc[4:0]]) begin
                            ref_e1[loc[13:5]][loc[4:0]] = 1'b1;
                            count++;
                        end
                    end else if (!ref_e0[pos[13:5]][pos[4:0]]) begin
                        ref_e0[pos[13:5]][pos[4:0]] = 1'b1;
                        count++;
                    end
                end
            end
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic expect_idle_outputs();
        check_flag("DONE", DONE, 1'b0);
        check_flag("KECCAK_ENABLE", KECCAK_ENABLE, 1'b0);
        check_flag("KECCAK_INIT", KECCAK_INIT, 1'b0);
        check_flag("rden_e0", rden_e0, 1'b0);
        check_flag("wren_e0", wren_e0, 1'b0);
        check_flag("rden_e1", rden_e1, 1'b0);
        check_flag("wren_e1", wren_e1, 1'b0);
    endtask

    task automatic compare_message();
        logic [`STATE_WIDTH-1:0] exp;
        exp = '0;
        for (int i = 0; i < 32; i++) begin
            exp[8*i +: 8] = KECCAK_SEED[8*(31-i) +: 8];
        end
        exp[260:256] = 5'h1f;
        exp[1087]    = 1'b1;
        check_msg("KECCAK_M", KECCAK_M, exp);
    endtask

    // Start a run, wait for DONE, compare both banks and strobe counts
    task automatic run_and_check();
        int bits;
        int cycles;
        @(posedge CLK);
        ENABLE <= 1'b1;
        @(posedge CLK);
        ENABLE <= 1'b0;
        cycles = 0;
        while (DONE !== 1'b1) begin
            @(negedge CLK);
            cycles++;
            if (cycles > MAX_DIGESTS * CYC_PER_DIGEST) begin
                fail_now("DONE never went high during the run");
            end
        end
        build_reference();
        bits = 0;
        for (int i = 0; i < 512; i++) begin
            check_word($sformatf("mem_e0[%0d]", i), mem_e0[i], ref_e0[i]);
            check_word($sformatf("mem_e1[%0d]", i), mem_e1[i], ref_e1[i]);
            bits += $countones(mem_e0[i]) + $countones(mem_e1[i]);
        end
        check_word("set bits", bits, `ERROR_WEIGHT);
        check_word("RAM writes", write_count, `ERROR_WEIGHT);
        check_word("KECCAK_INIT pulses", init_count, 1);
        check_word("KECCAK_ENABLE pulses", enable_count, ref_digests);
    endtask

    task automatic craft_digests();
        logic [31:0] words [9];
        words = '{32'd24646, 32'd32767, 32'habcd_0005, 32'd5, 32'd12323,
                  32'hffff_b023, 32'd12322, 32'd24645, 32'd24645};
        for (int k = 0; k < `WORDS_PER_DIGEST; k++) begin
            digest_bank[0] = put_word(digest_bank[0], k, (k < 9) ? words[k] : 32'd30000);
            digest_bank[1] = put_word(digest_bank[1], k, 32'h0000_7fff - k);
        end
    endtask

    task automatic watch_done_hold();
        repeat (20) begin
            @(negedge CLK);
            check_flag("DONE", DONE, 1'b1);
        end
    endtask

    initial begin
        RESETN      <= 1'b0;
        ENABLE      <= 1'b0;
        KECCAK_DONE <= 1'b0;
        KECCAK_OUT  <= '0;
        KECCAK_SEED <= '0;
        rdata_e0    <= '0;
        rdata_e1    <= '0;
        ram_clear   <= 1'b1;
        lcg_state   = 32'hbcb9539d;

        reset_dut();
        expect_idle_outputs();
        new_seed();
        @(negedge CLK);
        compare_message();
        fill_digests();
        run_and_check();
        watch_done_hold();

        // Crafted rejects and duplicates ahead of random digests
        reset_dut();
        expect_idle_outputs();
        fill_digests();
        craft_digests();
        run_and_check();

        // Second run after reset with a new seed
        reset_dut();
        check_flag("DONE", DONE, 1'b0);
        new_seed();
        @(negedge CLK);
        compare_message();
        fill_digests();
        run_and_check();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/error_sampler_props.sv */
`timescale 1ns/1ps
`default_nettype none

module error_sampler_props (
    input wire logic CLK,
    input wire logic RESETN,
    input wire logic DONE,
    input wire logic KECCAK_INIT,
    input wire logic KECCAK_ENABLE,
    input wire logic rden_e0,
    input wire logic wren_e0,
    input wire logic rden_e1,
    input wire logic wren_e1
);

    // ----------------------------------------
    // Port rules
    // ----------------------------------------
    // One bank active at a time
    assert property (@(posedge CLK) disable iff (!RESETN)
        !((rden_e0 || wren_e0) && (rden_e1 || wren_e1)))
        else $error("both RAM banks enabled together");

    // Init only with a digest request
    assert property (@(posedge CLK) disable iff (!RESETN) KECCAK_INIT |-> KECCAK_ENABLE)
        else $error("KECCAK_INIT without KECCAK_ENABLE");

    // DONE sticks until reset
    assert property (@(posedge CLK) (DONE && RESETN) |=> (DONE || !RESETN))
        else $error("DONE dropped while out of reset");

endmodule

bind error_sampler error_sampler_props u_props (
    .CLK(CLK), .RESETN(RESETN), .DONE(DONE), .KECCAK_INIT(KECCAK_INIT),
    .KECCAK_ENABLE(KECCAK_ENABLE), .rden_e0(rden_e0), .wren_e0(wren_e0),
    .rden_e1(rden_e1), .wren_e1(wren_e1)
);

`default_nettype wire

/* logic/error_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sampler_defines.svh"

module error_sampler import sampler_pkg::*; (
    input  wire logic                     CLK,
    input  wire logic                     RESETN,
    input  wire logic                     ENABLE,
    output logic                          DONE,
    // Keccak core
    input  wire logic [`SEED_WIDTH-1:0]   KECCAK_SEED,
    output logic      [`STATE_WIDTH-1:0]  KECCAK_M,
    output logic                          KECCAK_INIT,
    output logic                          KECCAK_ENABLE,
    input  wire logic                     KECCAK_DONE,
    input  wire logic [`STATE_WIDTH-1:0]  KECCAK_OUT,
    // Bank RAMs
    output logic                          rden_e0,
    output logic                          wren_e0,
    output logic                          rden_e1,
    output logic                          wren_e1,
    output logic      [`ADDR_WIDTH-1:0]   addr,
    output logic      [`WORD_WIDTH-1:0]   wdata,
    input  wire logic [`WORD_WIDTH-1:0]   rdata_e0,
    input  wire logic [`WORD_WIDTH-1:0]   rdata_e1
);

    logic                       capture;
    logic [`WORD_IDX_WIDTH-1:0] word_idx;
    logic [`WORD_WIDTH-1:0]     rand_word;
    logic                       load;
    logic                       pos_valid;
    bank_t                      bank;
    logic [`ADDR_WIDTH-1:0]     word_addr;
    logic [`WORD_WIDTH-1:0]     bit_mask;
    logic                       read_en;
    logic                       write_en;
    logic                       clear;
    logic                       weight_reached;

    // ----------------------------------------
    // Stage chain
    // ----------------------------------------
    digest_buffer u_digest (
        .CLK(CLK), .RESETN(RESETN), .seed(KECCAK_SEED), .keccak_m(KECCAK_M),
        .keccak_out(KECCAK_OUT), .capture(capture), .word_idx(word_idx),
        .rand_word(rand_word)
    );

    position_decode u_decode (
        .CLK(CLK), .RESETN(RESETN), .load(load), .rand_word(rand_word),
        .pos_valid(pos_valid), .bank(bank), .word_addr(word_addr), .bit_mask(bit_mask)
    );

    bit_insert u_insert (
        .CLK(CLK), .RESETN(RESETN), .clear(clear), .read_en(read_en),
        .write_en(write_en), .pos_valid(pos_valid), .bank(bank),
        .word_addr(word_addr), .bit_mask(bit_mask), .rden_e0(rden_e0),
        .wren_e0(wren_e0), .rden_e1(rden_e1), .wren_e1(wren_e1), .addr(addr),
        .wdata(wdata), .rdata_e0(rdata_e0), .rdata_e1(rdata_e1),
        .weight_reached(weight_reached)
    );

    // Sequences the three stages above
    sampler_control u_control (
        .CLK(CLK), .RESETN(RESETN), .enable(ENABLE), .keccak_done(KECCAK_DONE),
        .weight_reached(weight_reached), .keccak_init(KECCAK_INIT),
        .keccak_enable(KECCAK_ENABLE), .capture(capture), .word_idx(word_idx),
        .load(load), .read_en(read_en), .write_en(write_en), .clear(clear),
        .done(DONE)
    );

endmodule

`default_nettype wire

/* logic/sampler_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sampler_defines.svh"

module sampler_control import sampler_pkg::*; (
    input  wire logic                       CLK,
    input  wire logic                       RESETN,
    input  wire logic                       enable,
    input  wire logic                       keccak_done,
    input  wire logic                       weight_reached,
    output logic                            keccak_init,
    output logic                            keccak_enable,
    output logic                            capture,
    output logic      [`WORD_IDX_WIDTH-1:0] word_idx,
    output logic                            load,
    output logic                            read_en,
    output logic                            write_en,
    output logic                            clear,
    output logic                            done
);

    sampler_state_t state;
    sampler_state_t state_next;
    // Digest sits in the buffer, first word not yet decoded
    logic           digest_ready;
    // Word counter has run past the last word
    logic           words_used;

    assign words_used = (word_idx == `WORD_IDX_WIDTH'(`WORDS_PER_DIGEST));

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (enable) begin
                    state_next = ST_KECCAK_START;
                end
            end
            // Both requests are single-cycle strobes
            ST_KECCAK_START, ST_KECCAK_NEXT: begin
                state_next = ST_KECCAK_WAIT;
            end
            ST_KECCAK_WAIT: begin
                if (digest_ready) begin
                    state_next = ST_READ;
                end
            end
            ST_READ: begin
                state_next = ST_WRITE;
            end
            ST_WRITE: begin
                if (weight_reached) begin
                    state_next = ST_DONE;
                end else if (words_used) begin
                    state_next = ST_KECCAK_NEXT;
                end else begin
                    state_next = ST_READ;
                end
            end
            // Held until reset
            ST_DONE: begin
                state_next = ST_DONE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // State and counters
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state        <= ST_IDLE;
            word_idx     <= '0;
            digest_ready <= 1'b0;
        end else begin
            state <= state_next;
            if (capture) begin
                digest_ready <= 1'b1;
            end else if (load) begin
                digest_ready <= 1'b0;
            end
            // Restart at word 0 with every digest request
            if (keccak_enable) begin
                word_idx <= '0;
            end else if (read_en) begin
                // Points at the next word during write
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign keccak_init   = (state == ST_KECCAK_START);
    assign keccak_enable = (state == ST_KECCAK_START) || (state == ST_KECCAK_NEXT);
    assign capture       = (state == ST_KECCAK_WAIT) && !digest_ready && keccak_done;
    // First word after capture, later words overlap the write
    assign load = ((state == ST_KECCAK_WAIT) && digest_ready)
               || ((state == ST_WRITE) && !weight_reached && !words_used);
    assign read_en  = (state == ST_READ);
    assign write_en = (state == ST_WRITE);
    // Fresh weight count per run
    assign clear    = (state == ST_IDLE) && enable;
    assign done     = (state == ST_DONE);

endmodule

`default_nettype wire

/* logic/bit_insert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sampler_defines.svh"

module bit_insert import sampler_pkg::*; (
    input  wire logic                   CLK,
    input  wire logic                   RESETN,
    input  wire logic                   clear,
    input  wire logic                   read_en,
    input  wire logic                   write_en,
    input  wire logic                   pos_valid,
    input  wire bank_t                  bank,
    input  wire logic [`ADDR_WIDTH-1:0] word_addr,
    input  wire logic [`WORD_WIDTH-1:0] bit_mask,
    output logic                        rden_e0,
    output logic                        wren_e0,
    output logic                        rden_e1,
    output logic                        wren_e1,
    output logic      [`ADDR_WIDTH-1:0] addr,
    output logic      [`WORD_WIDTH-1:0] wdata,
    input  wire logic [`WORD_WIDTH-1:0] rdata_e0,
    input  wire logic [`WORD_WIDTH-1:0] rdata_e1,
    output logic                        weight_reached
);

    logic [`WORD_WIDTH-1:0]   rdata;
    logic                     bit_set;
    logic                     accept;
    logic [`WEIGHT_WIDTH-1:0] count;
    logic [`WEIGHT_WIDTH-1:0] count_next;

    // ----------------------------------------
    // Bank steering
    // ----------------------------------------
    assign rden_e0 = read_en && (bank == BANK_E0);
    assign rden_e1 = read_en && (bank == BANK_E1);
    // Same word address for read and write back
    assign addr    = word_addr;
    assign rdata   = (bank == BANK_E1) ? rdata_e1 : rdata_e0;

    // Read-modify-write merge
    assign bit_set = |(rdata & bit_mask);
    // Duplicates and rejected candidates leave the RAM untouched
    assign accept  = write_en && pos_valid && !bit_set;
    assign wren_e0 = accept && (bank == BANK_E0);
    assign wren_e1 = accept && (bank == BANK_E1);
    assign wdata   = rdata | bit_mask;

    // ----------------------------------------
    // Weight counter
    // ----------------------------------------
    assign count_next = accept ? count + 1'b1 : count;
    // Includes the write in flight so control can stop right after it
    assign weight_reached = (count_next == `WEIGHT_WIDTH'(`ERROR_WEIGHT));

    always_ff @(posedge CLK) begin
        if (!RESETN || clear) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

`default_nettype wire

/* logic/position_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sampler_defines.svh"

module position_decode import sampler_pkg::*; (
    input  wire logic                   CLK,
    input  wire logic                   RESETN,
    input  wire logic                   load,
    input  wire logic [`WORD_WIDTH-1:0] rand_word,
    output logic                        pos_valid,
    output bank_t                       bank,
    output logic      [`ADDR_WIDTH-1:0] word_addr,
    output logic      [`WORD_WIDTH-1:0] bit_mask
);

    logic [`POS_WIDTH-1:0] pos;
    // Position inside the selected bank
    logic [`POS_WIDTH-1:0] pos_local;
    logic                  in_range;
    logic                  upper;

    // ----------------------------------------
    // Candidate decode
    // ----------------------------------------
    assign pos      = rand_word[`POS_WIDTH-1:0];
    // Rejection sampling against n
    assign in_range = (pos < `POS_WIDTH'(`N_BITS));
    // Second half of e lives in bank 1
    assign upper    = (pos >= `POS_WIDTH'(`R_BITS));
    assign pos_local = upper ? pos - `POS_WIDTH'(`R_BITS) : pos;

    // Control part of the decode
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            pos_valid <= 1'b0;
            bank      <= BANK_E0;
        end else if (load) begin
            pos_valid <= in_range;
            bank      <= upper ? BANK_E1 : BANK_E0;
        end
    end

    // Word address and one-hot bit within it
    always_ff @(posedge CLK) begin
        if (load) begin
            word_addr <= pos_local[`ADDR_WIDTH+4:5];
            bit_mask  <= `WORD_WIDTH'(1) << pos_local[4:0];
        end
    end

endmodule

`default_nettype wire

/* logic/digest_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sampler_defines.svh"

module digest_buffer (
    input  wire logic [`SEED_WIDTH-1:0]     seed,
    input  wire logic                       CLK,
    input  wire logic                       RESETN,
    output logic      [`STATE_WIDTH-1:0]    keccak_m,
    input  wire logic [`STATE_WIDTH-1:0]    keccak_out,
    input  wire logic                       capture,
    input  wire logic [`WORD_IDX_WIDTH-1:0] word_idx,
    output logic      [`WORD_WIDTH-1:0]     rand_word
);

    logic [`DIGEST_WIDTH-1:0] digest_q;
    // Selected word, still in digest byte order
    logic [`WORD_WIDTH-1:0]   raw_word;

    // ----------------------------------------
    // Keccak message
    // ----------------------------------------
    always_comb begin
        keccak_m = '0;
        // Seed bytes go in reversed order
        for (int i = 0; i < `SEED_WIDTH / 8; i++) begin
            keccak_m[8*i +: 8] = seed[`SEED_WIDTH - 8 - 8*i +: 8];
        end
        // Domain padding right above the seed
        keccak_m[`SEED_WIDTH +: 5] = 5'b11111;
        // Last pad bit, top of the rate
        keccak_m[`DIGEST_WIDTH-1] = 1'b1;
    end

    // ----------------------------------------
    // Digest capture
    // ----------------------------------------
    // Keccak output only holds for the done cycle
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            digest_q <= '0;
        end else if (capture) begin
            digest_q <= keccak_out[`STATE_WIDTH-1 -: `DIGEST_WIDTH];
        end
    end

    // Word k starts at byte 4k counted from the top
    always_comb begin
        raw_word = '0;
        for (int k = 0; k < `WORDS_PER_DIGEST; k++) begin
            if (word_idx == `WORD_IDX_WIDTH'(k)) begin
                raw_word = digest_q[`DIGEST_WIDTH - `WORD_WIDTH*(k+1) +: `WORD_WIDTH];
            end
        end
    end

    // First digest byte becomes the least significant
    assign rand_word = {raw_word[7:0], raw_word[15:8], raw_word[23:16], raw_word[31:24]};

endmodule

`default_nettype wire

/* logic/sampler_pkg.sv */
`default_nettype none

package sampler_pkg;

    // Sampler control states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_KECCAK_START,
        ST_KECCAK_NEXT,
        ST_KECCAK_WAIT,
        ST_READ,
        ST_WRITE,
        ST_DONE
    } sampler_state_t;

    // Target half of the error vector
    typedef enum logic {
        BANK_E0,
        BANK_E1
    } bank_t;

endpackage

`default_nettype wire

/* logic/sampler_defines.svh */
`ifndef SAMPLER_DEFINES_SVH
`define SAMPLER_DEFINES_SVH

// ----------------------------------------
// Error vector geometry
// ----------------------------------------
// Bits per bank, one bank per half of e
`define R_BITS 12323
// Full error vector, both halves
`define N_BITS 24646
// Low bits of each random word taken as candidate
`define POS_WIDTH 15

// ----------------------------------------
// Bank RAM shape
// ----------------------------------------
`define ADDR_WIDTH 9
`define WORD_WIDTH 32

// Distinct positions to set before the run ends
`define ERROR_WEIGHT 134
`define WEIGHT_WIDTH 8

// ----------------------------------------
// Keccak message and digest layout
// ----------------------------------------
`define SEED_WIDTH 256
`define STATE_WIDTH 1600
`define DIGEST_WIDTH 1088
`define WORDS_PER_DIGEST 34
`define WORD_IDX_WIDTH 6

`endif
